/* Makefile */
TOP := tb_core

sim:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* all.f */
+incdir+hw
hw/core_types_pkg.sv
hw/core_ctrl_pkg.sv
hw/core_ifu.sv
hw/core_idu.sv
hw/core_regfile.sv
hw/core_csr.sv
hw/core_exu.sv
hw/core_top.sv
testbench/tb_core.sv

/* hw/core_csr.sv */
// machine csr file with csrrw and csrrs access plus ecall trap entry
`timescale 1ns/1ps
`default_nettype none

module core_csr (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  core_ctrl_pkg::ctrl_t  ctrl,
    input  core_types_pkg::word_t pc,
    input  core_types_pkg::word_t csr_wdata,
    output core_types_pkg::word_t csr_rdata,
    output core_types_pkg::word_t trap_vec,
    output core_types_pkg::word_t epc
);
    import core_types_pkg::*;

    localparam csr_addr_t addr_mtvec    = 12'h305;
    localparam csr_addr_t addr_mscratch = 12'h340;
    localparam csr_addr_t addr_mepc     = 12'h341;
    localparam csr_addr_t addr_mcause   = 12'h342;

    word_t mscratch;
    word_t mtvec;
    word_t mepc;
    word_t mcause;
    word_t new_val;
    logic  csr_wr;

    // old value, returned to rd
    always_comb begin
        case (ctrl.csr_addr)
            addr_mtvec:    csr_rdata = mtvec;
            addr_mscratch: csr_rdata = mscratch;
            addr_mepc:     csr_rdata = mepc;
            addr_mcause:   csr_rdata = mcause;
            default:       csr_rdata = '0;
        endcase
    end

    assign csr_wr  = run && (ctrl.csr_we || ctrl.csr_set);
    // csrrs with rs1 zero leaves value as is
    assign new_val = ctrl.csr_set ? (csr_rdata | csr_wdata) : csr_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else begin
            if (csr_wr) begin
                case (ctrl.csr_addr)
                    addr_mtvec:    mtvec    <= new_val;
                    addr_mscratch: mscratch <= new_val;
                    addr_mepc:     mepc     <= new_val;
                    addr_mcause:   mcause   <= new_val;
                    default: ;
                endcase
            end
            // ecall from m-mode, cause 11
            if (run && ctrl.ecall) begin
                mepc   <= pc;
                mcause <= 32'd11;
            end
        end
    end

    assign trap_vec = mtvec;
    assign epc      = mepc;

endmodule

`default_nettype wire

/* hw/core_ctrl_pkg.sv */
// decoded control word and its select enums, produced by the decoder and read by the units
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_sltu, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {opa_reg, opa_pc, opa_zero} opa_sel_e;
    typedef enum logic {opb_reg, opb_imm} opb_sel_e;

    // next pc source
    typedef enum logic [2:0] {
        pc_plus4, pc_branch, pc_jal, pc_jalr, pc_trap, pc_mret
    } pc_sel_e;

    typedef enum logic [2:0] {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_e;

    // write-back source
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4, wb_csr} wb_sel_e;

    typedef struct packed {
        logic                      reg_we;
        core_types_pkg::reg_addr_t rs1;
        core_types_pkg::reg_addr_t rs2;
        core_types_pkg::reg_addr_t rd;
        alu_op_e                   alu_op;
        opa_sel_e                  opa_sel;
        opb_sel_e                  opb_sel;
        pc_sel_e                   pc_sel;
        br_cond_e                  br_cond;
        logic                      mem_rd;
        logic                      mem_wr;
        wb_sel_e                   wb_sel;
        // csrrw writes, csrrs sets bits
        logic                      csr_we;
        logic                      csr_set;
        core_types_pkg::csr_addr_t csr_addr;
        logic                      ecall;
        logic                      mret;
    } ctrl_t;

endpackage

`default_nettype wire

/* hw/core_exu.sv */
// execute unit with alu, branch compare, next-pc select, data memory and write-back mux
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_exu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  core_ctrl_pkg::ctrl_t  ctrl,
    input  core_types_pkg::word_t imm,
    input  core_types_pkg::word_t pc,
    input  core_types_pkg::word_t rs1_data,
    input  core_types_pkg::word_t rs2_data,
    input  core_types_pkg::word_t csr_rdata,
    input  core_types_pkg::word_t trap_vec,
    input  core_types_pkg::word_t epc,
    output core_types_pkg::word_t next_pc,
    output core_types_pkg::word_t rd_wdata,
    output core_types_pkg::word_t csr_wdata
);
    import core_types_pkg::*;
    import core_ctrl_pkg::*;

    localparam int dmem_aw = $clog2(`DMEM_DEPTH);

    word_t              dmem [`DMEM_DEPTH];
    word_t              op_a;
    word_t              op_b;
    word_t              alu_res;
    word_t              pc_plus4;
    word_t              load_data;
    logic [dmem_aw-1:0] dmem_idx;
    logic               br_taken;

    // operand select
    always_comb begin
        case (ctrl.opa_sel)
            opa_pc:   op_a = pc;
            opa_zero: op_a = '0;
            default:  op_a = rs1_data;
        endcase
    end
    assign op_b = (ctrl.opb_sel == opb_imm) ? imm : rs2_data;

    // shifts use the low five bits of b
    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_slt:  alu_res = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = word_t'(op_a < op_b);
            default:  alu_res = op_b;
        endcase
    end

    // branch compare on rs1 and rs2
    always_comb begin
        case (ctrl.br_cond)
            br_eq:   br_taken = (rs1_data == rs2_data);
            br_ne:   br_taken = (rs1_data != rs2_data);
            br_lt:   br_taken = ($signed(rs1_data) < $signed(rs2_data));
            br_ge:   br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            br_ltu:  br_taken = (rs1_data < rs2_data);
            default: br_taken = (rs1_data >= rs2_data);
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.pc_sel)
            pc_branch: next_pc = br_taken ? pc + imm : pc_plus4;
            pc_jal:    next_pc = pc + imm;
            // jalr target with bit 0 cleared
            pc_jalr:   next_pc = (rs1_data + imm) & ~word_t'(1);
            pc_trap:   next_pc = trap_vec;
            pc_mret:   next_pc = epc;
            default:   next_pc = pc_plus4;
        endcase
    end

    // word-addressed data memory
    assign dmem_idx  = alu_res[dmem_aw+1:2];
    assign load_data = ctrl.mem_rd ? dmem[dmem_idx] : '0;

    // no stores while reset held
    always_ff @(posedge clk) begin
        if (arst_n && run && ctrl.mem_wr) begin
            dmem[dmem_idx] <= rs2_data;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_load: rd_wdata = load_data;
            wb_pc4:  rd_wdata = pc_plus4;
            wb_csr:  rd_wdata = csr_rdata;
            default: rd_wdata = alu_res;
        endcase
    end

    // csr source is rs1
    assign csr_wdata = rs1_data;

endmodule

`default_nettype wire

/* hw/core_idu.sv */
// instruction decoder turning one instruction into the control word and its immediate
`timescale 1ns/1ps
`default_nettype none

module core_idu (
    input  core_types_pkg::word_t inst,
    output core_ctrl_pkg::ctrl_t  ctrl,
    output core_types_pkg::word_t imm
);
    import core_ctrl_pkg::*;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    // funct7 bit 5 picks sub and sra
    logic       alt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    function automatic alu_op_e alu_of(input logic [2:0] f3, input logic sub_sra);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = sub_sra ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // immediate by format, i-type as fallback
    always_comb begin
        case (opcode)
            op_lui, op_auipc: imm = {inst[31:12], 12'b0};
            op_jal:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            op_branch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            op_store:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:   imm = {{21{inst[31]}}, inst[30:20]};
        endcase
    end

    always_comb begin
        // no-op baseline, all enables off
        ctrl          = '0;
        ctrl.rs1      = inst[18:15];
        ctrl.rs2      = inst[23:20];
        ctrl.rd       = inst[10:7];
        ctrl.alu_op   = alu_pass_b;
        ctrl.opa_sel  = opa_reg;
        ctrl.opb_sel  = opb_imm;
        ctrl.pc_sel   = pc_plus4;
        ctrl.wb_sel   = wb_alu;
        ctrl.csr_addr = inst[31:20];
        case (opcode)
            op_lui, op_auipc: begin
                ctrl.reg_we  = 1'b1;
                ctrl.opa_sel = (opcode == op_lui) ? opa_zero : opa_pc;
                ctrl.alu_op  = alu_add;
            end
            op_jal, op_jalr: begin
                ctrl.reg_we = 1'b1;
                ctrl.pc_sel = (opcode == op_jal) ? pc_jal : pc_jalr;
                ctrl.wb_sel = wb_pc4;
            end
            op_branch: begin
                ctrl.pc_sel = pc_branch;
                case (funct3)
                    3'b000:  ctrl.br_cond = br_eq;
                    3'b001:  ctrl.br_cond = br_ne;
                    3'b100:  ctrl.br_cond = br_lt;
                    3'b101:  ctrl.br_cond = br_ge;
                    3'b110:  ctrl.br_cond = br_ltu;
                    default: ctrl.br_cond = br_geu;
                endcase
            end
            op_load: begin
                ctrl.reg_we = 1'b1;
                ctrl.mem_rd = 1'b1;
                ctrl.alu_op = alu_add;
                ctrl.wb_sel = wb_load;
            end
            op_store: begin
                ctrl.mem_wr = 1'b1;
                ctrl.alu_op = alu_add;
            end
            op_imm: begin
                ctrl.reg_we = 1'b1;
                // addi ignores bit 30, srai uses it
                ctrl.alu_op = alu_of(funct3, (funct3 == 3'b101) && alt);
            end
            op_reg: begin
                ctrl.reg_we  = 1'b1;
                ctrl.opb_sel = opb_reg;
                ctrl.alu_op  = alu_of(funct3, alt);
            end
            op_system: begin
                if (funct3 == 3'b000 && inst[31:20] == 12'h000) begin
                    ctrl.ecall  = 1'b1;
                    ctrl.pc_sel = pc_trap;
                end else if (funct3 == 3'b000 && inst[31:20] == 12'h302) begin
                    ctrl.mret   = 1'b1;
                    ctrl.pc_sel = pc_mret;
                end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    ctrl.reg_we  = 1'b1;
                    ctrl.csr_we  = (funct3 == 3'b001);
                    ctrl.csr_set = (funct3 == 3'b010);
                    ctrl.wb_sel  = wb_csr;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/core_ifu.sv */
// fetch unit holding the pc register and the instruction memory with its load port
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_ifu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  core_types_pkg::imem_load_t imem_load,
    input  core_types_pkg::word_t      next_pc,
    output core_types_pkg::word_t      pc,
    output core_types_pkg::word_t      inst
);
    import core_types_pkg::*;

    word_t      imem [`IMEM_DEPTH];
    imem_addr_t pc_idx;

    // word index, low two pc bits dropped
    assign pc_idx = pc[$bits(imem_addr_t)+1:2];
    assign inst   = imem[pc_idx];

    // pc only moves in run mode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    // program load while halted
    always_ff @(posedge clk) begin
        if (!run && imem_load.we) begin
            imem[imem_load.addr] <= imem_load.data;
        end
    end

endmodule

`default_nettype wire

/* hw/core_macros.svh */
// core-wide sizes and reset values, included by the type package and the memory units
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path width in bits
`define XLEN_W 32

// rv32e register count
`define REG_CNT 16

// instruction memory depth in words, sized per program
`define IMEM_DEPTH 64

// data memory depth in words
`define DMEM_DEPTH 64

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* hw/core_regfile.sv */
// sixteen-entry register file with two combinational reads and one clocked write
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_regfile (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      run,
    input  logic                      wen,
    input  core_types_pkg::reg_addr_t waddr,
    input  core_types_pkg::reg_addr_t raddr1,
    input  core_types_pkg::reg_addr_t raddr2,
    input  core_types_pkg::word_t     wdata,
    output core_types_pkg::word_t     rdata1,
    output core_types_pkg::word_t     rdata2
);
    import core_types_pkg::*;

    word_t regs [`REG_CNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (run && wen && waddr != '0) begin
            // x0 writes dropped here
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hw/core_top.sv */
// core top level wiring fetch, decode, registers, csrs and execute, exposing pc and retire
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  core_types_pkg::imem_load_t imem_load,
    output core_types_pkg::word_t      pc,
    output core_types_pkg::retire_t    retire
);
    import core_types_pkg::*;
    import core_ctrl_pkg::*;

    word_t inst;
    word_t imm;
    word_t next_pc;
    word_t rs1_data;
    word_t rs2_data;
    word_t rd_wdata;
    word_t csr_rdata;
    word_t csr_wdata;
    word_t trap_vec;
    word_t epc;
    ctrl_t ctrl;

    core_ifu u_ifu (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .imem_load (imem_load),
        .next_pc   (next_pc),
        .pc        (pc),
        .inst      (inst)
    );

    core_idu u_idu (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    core_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),
        .wen    (ctrl.reg_we),
        .waddr  (ctrl.rd),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .wdata  (rd_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    core_csr u_csr (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .ctrl      (ctrl),
        .pc        (pc),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .trap_vec  (trap_vec),
        .epc       (epc)
    );

    core_exu u_exu (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .ctrl      (ctrl),
        .imm       (imm),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_rdata (csr_rdata),
        .trap_vec  (trap_vec),
        .epc       (epc),
        .next_pc   (next_pc),
        .rd_wdata  (rd_wdata),
        .csr_wdata (csr_wdata)
    );

    // one retire per run cycle
    assign retire.valid  = run;
    assign retire.pc     = pc;
    // x0 targets count as no write
    assign retire.rd_we  = ctrl.reg_we && (ctrl.rd != '0);
    assign retire.rd     = ctrl.rd;
    assign retire.rd_val = rd_wdata;

endmodule

`default_nettype wire

/* hw/core_types_pkg.sv */
// datapath vector types plus the program load and retire records shared across the core
`default_nettype none
`include "core_macros.svh"

package core_types_pkg;

    // data or pc word
    typedef logic [`XLEN_W-1:0] word_t;
    // 4-bit register index for rv32e
    typedef logic [$clog2(`REG_CNT)-1:0] reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    // word index into instruction memory
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_t;

    // program load strobe, honoured only with run low
    typedef struct packed {
        logic       we;
        imem_addr_t addr;
        word_t      data;
    } imem_load_t;

    // one record per retired instruction
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rd_we;
        reg_addr_t rd;
        word_t     rd_val;
    } retire_t;

endpackage

`default_nettype wire

/* testbench/core_stim.txt */
# L byte_addr(hex) instruction(hex) ; E pc(hex) rd(dec) rd_value(hex)
# N retire count(dec) ; F final pc(hex) ; a # token comments to end of line
L 00 00500093  # addi x1, x0, 5
L 04 FFD00113  # addi x2, x0, -3
L 08 002081B3  # add x3, x1, x2
L 0C 40208233  # sub x4, x1, x2
L 10 0020C2B3  # xor x5, x1, x2
L 14 00112333  # slt x6, x2, x1
L 18 001133B3  # sltu x7, x2, x1
L 1C 40115413  # srai x8, x2, 1
L 20 00409493  # slli x9, x1, 4
L 24 001151B3  # srl x3, x2, x1
L 28 12345537  # lui x10, 0x12345
L 2C 00001597  # auipc x11, 1
L 30 00708013  # addi x0, x1, 7
L 34 00106633  # or x12, x0, x1
L 38 009176B3  # and x13, x2, x9
L 3C 00C08463  # beq x1, x12, +8 taken
L 44 00C09463  # bne x1, x12, +8 not taken
L 48 00C007EF  # jal x15, +12
L 54 00A02423  # sw x10, 8(x0)
L 58 00102623  # sw x1, 12(x0)
L 5C 00802703  # lw x14, 8(x0)
L 60 00C02683  # lw x13, 12(x0)
L 64 07100193  # addi x3, x0, 0x71
L 68 000187E7  # jalr x15, 0(x3)
L 70 09000213  # addi x4, x0, 0x90
L 74 305212F3  # csrrw x5, mtvec, x4
L 78 34049373  # csrrw x6, mscratch, x9
L 7C 3400A3F3  # csrrs x7, mscratch, x1
L 80 34002473  # csrrs x8, mscratch, x0
L 84 00000073  # ecall
L 88 341025F3  # csrrs x11, mepc, x0
L 8C 0000006F  # jal x0, 0
L 90 342024F3  # trap handler, csrrs x9, mcause, x0
L 94 34102573  # csrrs x10, mepc, x0
L 98 00450513  # addi x10, x10, 4
L 9C 34151073  # csrrw x0, mepc, x10
L A0 30200073  # mret
E 00 1 00000005
E 04 2 FFFFFFFD
E 08 3 00000002
E 0C 4 00000008
E 10 5 FFFFFFF8
E 14 6 00000001
E 18 7 00000000
E 1C 8 FFFFFFFE
E 20 9 00000050
E 24 3 07FFFFFF
E 28 10 12345000
E 2C 11 0000102C
E 34 12 00000005
E 38 13 00000050
E 48 15 0000004C
E 5C 14 12345000
E 60 13 00000005
E 64 3 00000071
E 68 15 0000006C
E 70 4 00000090
E 74 5 00000000
E 78 6 00000000
E 7C 7 00000050
E 80 8 00000055
E 90 9 0000000B
E 94 10 00000084
E 98 10 00000088
E 88 11 00000088
N 36
F 0000008C

/* testbench/tb_core.sv */
// core testbench, loads a program from the stim file, runs it and checks retires and pc
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module tb_core;
    import core_types_pkg::*;

    localparam int    half_period  = 10;
    localparam int    seed         = 51;
    localparam int    reset_cycles = 16;
    // cycles allowed while waiting for one expected retire
    localparam int    wait_limit   = 32;
    // sample point after the falling edge, clear of both edges
    localparam int    sample_delay = 2;
    localparam string stim_path    = "testbench/core_stim.txt";

    logic       clk;
    logic       arst_n;
    logic       run;
    imem_load_t imem_load;
    word_t      pc;
    retire_t    retire;

    // program image, byte address and word
    word_t     prog_addr [$];
    word_t     prog_data [$];
    // expected register writes in retire order
    word_t     exp_pc [$];
    reg_addr_t exp_rd [$];
    word_t     exp_val [$];
    int        retire_total;
    word_t     final_pc;
    int        retired;
    int        idle_cycles;

    core_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .imem_load (imem_load),
        .pc        (pc),
        .retire    (retire)
    );

    always #half_period clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // records L, E, N, F; a # token skips to end of line
    task automatic read_stim();
        int                 fd;
        int                 code;
        int                 rd;
        logic [7:0]         tag;
        word_t              a;
        word_t              d;
        logic [8*160-1:0]   rest;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            stop_run("the stim file testbench/core_stim.txt could not be opened");
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);
                "L": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    prog_addr.push_back(a);
                    prog_data.push_back(d);
                end
                "E": begin
                    code = $fscanf(fd, "%h %d %h", a, rd, d);
                    exp_pc.push_back(a);
                    exp_rd.push_back(reg_addr_t'(rd));
                    exp_val.push_back(d);
                end
                "N": code = $fscanf(fd, "%d", retire_total);
                "F": code = $fscanf(fd, "%h", final_pc);
                default: stop_run($sformatf("the stim file holds an unknown record %s", tag));
            endcase
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    // one word per falling edge, strobe dropped after the last
    task automatic load_program();
        foreach (prog_addr[i]) begin
            @(negedge clk);
            if (prog_addr[i] >= word_t'(`IMEM_DEPTH * 4)) begin
                stop_run($sformatf("program address %h lies outside instruction memory",
                                   prog_addr[i]));
            end
            imem_load.we   = 1'b1;
            imem_load.addr = imem_addr_t'(prog_addr[i] >> 2);
            imem_load.data = prog_data[i];
        end
        @(negedge clk);
        imem_load = '0;
    endtask

    // entered and left on a falling edge
    task automatic await_write(input int idx);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found) begin
            #sample_delay;
            if (retire.valid) begin
                retired++;
                if (retired > retire_total) begin
                    stop_run("more instructions retired than the stim file allows");
                end
                if (retire.rd_we) begin
                    check_word($sformatf("write %0d pc", idx), exp_pc[idx], retire.pc);
                    check_reg($sformatf("write %0d rd", idx), exp_rd[idx], retire.rd);
                    check_word($sformatf("write %0d value", idx), exp_val[idx], retire.rd_val);
                    found = 1'b1;
                end
            end
            @(negedge clk);
            cycles++;
            if (!found && cycles >= wait_limit) begin
                stop_run($sformatf("no register write for record %0d within %0d cycles",
                                   idx, wait_limit));
            end
        end
    endtask

    // instructions after the last write, none of them may write
    task automatic drain_retires();
        int cycles;
        cycles = 0;
        while (retired < retire_total) begin
            #sample_delay;
            if (retire.valid) begin
                retired++;
                if (retire.rd_we) begin
                    stop_run($sformatf("unlisted register write retired at pc %h", retire.pc));
                end
            end
            @(negedge clk);
            cycles++;
            if (retired < retire_total && cycles >= wait_limit) begin
                stop_run("the core stopped retiring before the expected count was reached");
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        imem_load    = '0;
        retired      = 0;
        retire_total = 0;
        final_pc     = '0;
        void'($urandom(seed));
        read_stim();
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        #sample_delay;
        check_word("pc after reset", `RESET_PC, pc);
        check_bit("retire valid after reset", 1'b0, retire.valid);
        load_program();
        // halted core keeps its reset pc during the load
        #sample_delay;
        check_word("pc after load", `RESET_PC, pc);
        check_bit("retire valid after load", 1'b0, retire.valid);
        idle_cycles = 1 + int'($urandom() % 32'd8);
        repeat (idle_cycles) @(negedge clk);
        run = 1'b1;
        foreach (exp_pc[i]) begin
            await_write(i);
        end
        drain_retires();
        // last instruction retired on the edge just passed
        run = 1'b0;
        #sample_delay;
        check_bit("retire valid after stop", 1'b0, retire.valid);
        check_word("final pc", final_pc, pc);
        @(negedge clk);
        #sample_delay;
        check_word("pc held with run low", final_pc, pc);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
